//--- rv_pipe_ctrl.f
src/rv_ctrl_pkg.sv
src/inst_decoder.sv
src/operand_hazard.sv
src/branch_resolver.sv
src/pipe_ctrl.sv
src/rv_pipe_ctrl.sv
tests/rv_pipe_ctrl_tb.sv

//--- src/branch_resolver.sv
// X-stage branch and JALR resolution from datapath compare flags
`default_nettype none

module branch_resolver import rv_ctrl_pkg::*; (
  input  x_branch_t xbr_i,
  input  br_cond_t  cond_i,
  output logic      redirect_o,
  output pc_sel_e   pc_sel_o
);

  always_comb begin
    redirect_o = 1'b0;
    pc_sel_o   = PC_PLUS4;
    if (xbr_i.val) begin
      // ne, ge, geu are the inverted eq, lt, ltu flags
      case (xbr_i.br_type)
        BR_BEQ:  redirect_o = cond_i.eq;
        BR_BNE:  redirect_o = !cond_i.eq;
        BR_BLT:  redirect_o = cond_i.lt;
        BR_BGE:  redirect_o = !cond_i.lt;
        BR_BLTU: redirect_o = cond_i.ltu;
        BR_BGEU: redirect_o = !cond_i.ltu;
        default: redirect_o = 1'b0;
      endcase
      if (xbr_i.br_type != BR_NONE) begin
        pc_sel_o = PC_BRANCH;
      end else if (xbr_i.jump == JUMP_JALR) begin
        // JALR always leaves the sequential path
        redirect_o = 1'b1;
        pc_sel_o   = PC_JALR;
      end
    end
  end

  always_comb begin
    assert final (!(redirect_o && !xbr_i.val))
      else $error("redirect from an invalid X stage");
  end

endmodule

`default_nettype wire

//--- src/inst_decoder.sv
// Combinational RV32I decode, no MUL and no CSR instructions
// Any illegal encoding decodes to a bubble word
`default_nettype none

module inst_decoder import rv_ctrl_pkg::*; (
  input  logic [XLEN-1:0] inst_i,
  output ctrl_word_t      ctrl_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       legal;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];

  always_comb begin
    // Zero word: no write, no memory op, no branch, no jump
    ctrl_o          = '0;
    ctrl_o.rf_waddr = inst_i[11:7];
    legal           = 1'b1;
    case (opcode)
      OPC_OP: begin
        ctrl_o.rs1_en         = 1'b1;
        ctrl_o.rs2_en         = 1'b1;
        ctrl_o.rf_wen_pending = 1'b1;
        legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        // funct7 bit 5 picks sub and sra
        case ({funct7[5], funct3})
          4'b0_000: ctrl_o.alu_fn = ALU_ADD;
          4'b1_000: ctrl_o.alu_fn = ALU_SUB;
          4'b0_001: ctrl_o.alu_fn = ALU_SLL;
          4'b0_010: ctrl_o.alu_fn = ALU_SLT;
          4'b0_011: ctrl_o.alu_fn = ALU_SLTU;
          4'b0_100: ctrl_o.alu_fn = ALU_XOR;
          4'b0_101: ctrl_o.alu_fn = ALU_SRL;
          4'b1_101: ctrl_o.alu_fn = ALU_SRA;
          4'b0_110: ctrl_o.alu_fn = ALU_OR;
          4'b0_111: ctrl_o.alu_fn = ALU_AND;
          default:  legal = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        ctrl_o.rs1_en         = 1'b1;
        ctrl_o.op2_sel        = OP2_IMM;
        ctrl_o.imm_type       = IMM_I;
        ctrl_o.rf_wen_pending = 1'b1;
        case (funct3)
          3'b000: ctrl_o.alu_fn = ALU_ADD;
          3'b010: ctrl_o.alu_fn = ALU_SLT;
          3'b011: ctrl_o.alu_fn = ALU_SLTU;
          3'b100: ctrl_o.alu_fn = ALU_XOR;
          3'b110: ctrl_o.alu_fn = ALU_OR;
          3'b111: ctrl_o.alu_fn = ALU_AND;
          3'b001: begin
            ctrl_o.alu_fn = ALU_SLL;
            legal         = (funct7 == 7'b0000000);
          end
          default: begin
            // Shift right, srai carries funct7 bit 5
            ctrl_o.alu_fn = funct7[5] ? ALU_SRA : ALU_SRL;
            legal         = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          end
        endcase
      end
      OPC_LUI: begin
        ctrl_o.op2_sel        = OP2_IMM;
        ctrl_o.imm_type       = IMM_U;
        ctrl_o.alu_fn         = ALU_CP2;
        ctrl_o.rf_wen_pending = 1'b1;
      end
      OPC_AUIPC: begin
        ctrl_o.op1_sel        = OP1_PC;
        ctrl_o.op2_sel        = OP2_IMM;
        ctrl_o.imm_type       = IMM_U;
        ctrl_o.rf_wen_pending = 1'b1;
      end
      // Word accesses only
      OPC_LOAD: begin
        legal                 = (funct3 == 3'b010);
        ctrl_o.rs1_en         = 1'b1;
        ctrl_o.op2_sel        = OP2_IMM;
        ctrl_o.mem_op         = MEM_LOAD;
        ctrl_o.wb_sel         = WB_MEM;
        ctrl_o.rf_wen_pending = 1'b1;
      end
      OPC_STORE: begin
        legal           = (funct3 == 3'b010);
        ctrl_o.rs1_en   = 1'b1;
        ctrl_o.rs2_en   = 1'b1;
        ctrl_o.op2_sel  = OP2_IMM;
        ctrl_o.imm_type = IMM_S;
        ctrl_o.mem_op   = MEM_STORE;
      end
      OPC_JAL: begin
        ctrl_o.jump           = JUMP_JAL;
        ctrl_o.imm_type       = IMM_J;
        ctrl_o.ex_sel         = EX_PC4;
        ctrl_o.rf_wen_pending = 1'b1;
      end
      OPC_JALR: begin
        legal                 = (funct3 == 3'b000);
        ctrl_o.jump           = JUMP_JALR;
        ctrl_o.rs1_en         = 1'b1;
        ctrl_o.op2_sel        = OP2_IMM;
        ctrl_o.ex_sel         = EX_PC4;
        ctrl_o.rf_wen_pending = 1'b1;
      end
      OPC_BRANCH: begin
        ctrl_o.rs1_en   = 1'b1;
        ctrl_o.rs2_en   = 1'b1;
        ctrl_o.imm_type = IMM_B;
        case (funct3)
          3'b000:  ctrl_o.br_type = BR_BEQ;
          3'b001:  ctrl_o.br_type = BR_BNE;
          3'b100:  ctrl_o.br_type = BR_BLT;
          3'b101:  ctrl_o.br_type = BR_BGE;
          3'b110:  ctrl_o.br_type = BR_BLTU;
          3'b111:  ctrl_o.br_type = BR_BGEU;
          default: legal = 1'b0;
        endcase
      end
      default: legal = 1'b0;
    endcase
    if (!legal) begin
      ctrl_o = '0;
    end
  end

  // Stores never reach the register file write port
  always_comb begin
    assert final (!(ctrl_o.mem_op == MEM_STORE && ctrl_o.rf_wen_pending))
      else $error("store decoded with a register write");
  end

endmodule

`default_nettype wire

//--- src/operand_hazard.sv
// D-stage bypass select and load-use detection
// Destinations arrive already qualified by their stage valid bits
`default_nettype none

module operand_hazard import rv_ctrl_pkg::*; (
  input  ctrl_word_t            ctrl_i,
  input  logic [REG_ADDR_W-1:0] rs1_i,
  input  logic [REG_ADDR_W-1:0] rs2_i,
  input  dest_info_t            dest_x_i,
  input  dest_info_t            dest_m_i,
  input  dest_info_t            dest_w_i,
  output byp_sel_e              op1_byp_o,
  output byp_sel_e              op2_byp_o,
  output logic                  load_use_o
);

  // Pending write to this source, x0 never matches
  function automatic logic hit(input dest_info_t dest, input logic [REG_ADDR_W-1:0] rs);
    return dest.wen && (dest.addr == rs) && (rs != '0);
  endfunction

  // Youngest writer wins, a load in X has no data yet
  function automatic byp_sel_e pick(input logic en, input logic [REG_ADDR_W-1:0] rs,
                                    input dest_info_t dx, input dest_info_t dm,
                                    input dest_info_t dw);
    if (!en) begin
      return BYP_RF;
    end
    if (hit(dx, rs) && !dx.is_load) begin
      return BYP_X;
    end
    if (hit(dm, rs)) begin
      return BYP_M;
    end
    if (hit(dw, rs)) begin
      return BYP_W;
    end
    return BYP_RF;
  endfunction

  assign op1_byp_o = pick(ctrl_i.rs1_en, rs1_i, dest_x_i, dest_m_i, dest_w_i);
  assign op2_byp_o = pick(ctrl_i.rs2_en, rs2_i, dest_x_i, dest_m_i, dest_w_i);

  // Load result is only available from M onwards
  assign load_use_o = dest_x_i.is_load &&
                      ((ctrl_i.rs1_en && hit(dest_x_i, rs1_i)) ||
                       (ctrl_i.rs2_en && hit(dest_x_i, rs2_i)));

endmodule

`default_nettype wire

//--- src/pipe_ctrl.sv
// Stage valids, control pipeline and stall/squash network, W never stalls
// Instruction memory must accept every request, imem_req_rdy_i is not waited on
// A squashed fetch response is flagged by imem_resp_drop_o for an external drop unit
`default_nettype none

module pipe_ctrl import rv_ctrl_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  ctrl_word_t   ctrl_d_i,
  input  byp_sel_e     op1_byp_i,
  input  byp_sel_e     op2_byp_i,
  input  logic         load_use_i,
  input  logic         redirect_x_i,
  input  pc_sel_e      pc_sel_x_i,
  output logic         imem_req_val_o,
  input  logic         imem_req_rdy_i,
  input  logic         imem_resp_val_i,
  output logic         imem_resp_rdy_o,
  output logic         imem_resp_drop_o,
  output logic         dmem_req_val_o,
  input  logic         dmem_req_rdy_i,
  output mem_op_e      dmem_req_type_o,
  input  logic         dmem_resp_val_i,
  output logic         dmem_resp_rdy_o,
  output dest_info_t   dest_x_o,
  output dest_info_t   dest_m_o,
  output dest_info_t   dest_w_o,
  output x_branch_t    xbr_o,
  output fetch_ctrl_t  fetch_ctrl_o,
  output decode_ctrl_t decode_ctrl_o,
  output exec_ctrl_t   exec_ctrl_o,
  output mem_ctrl_t    mem_ctrl_o,
  output wb_ctrl_t     wb_ctrl_o,
  output logic         commit_o
);

  logic val_f, val_d, val_x, val_m, val_w;
  logic ostall_f, ostall_d, ostall_x, ostall_m;
  logic stall_f, stall_d, stall_x, stall_m;
  logic osquash_d, osquash_x;
  logic squash_f, squash_d;
  logic reg_en_f, reg_en_d, reg_en_x, reg_en_m;
  logic next_val_f, next_val_d, next_val_x, next_val_m;
  logic reset_q;

  // Pipelined control fields
  ctrl_word_t            ctrl_x;
  mem_op_e               mem_op_m;
  wb_sel_e               wb_sel_m;
  logic                  rf_wen_m;
  logic [REG_ADDR_W-1:0] waddr_m;
  logic                  rf_wen_w;
  logic [REG_ADDR_W-1:0] waddr_w;

  // ------------------------------
  // Stall and squash network
  // ------------------------------

  assign ostall_f = val_f && !imem_resp_val_i;
  assign ostall_d = val_d && load_use_i;
  assign ostall_x = val_x && (ctrl_x.mem_op != MEM_NONE) && !dmem_req_rdy_i;
  assign ostall_m = val_m && (mem_op_m != MEM_NONE) && !dmem_resp_val_i;

  // A stage holds when it or anything ahead of it holds
  assign stall_f = val_f && (ostall_f || ostall_d || ostall_x || ostall_m);
  assign stall_d = val_d && (ostall_d || ostall_x || ostall_m);
  assign stall_x = val_x && (ostall_x || ostall_m);
  assign stall_m = val_m && ostall_m;

  // JAL resolves in D, branches and JALR in X
  assign osquash_d = val_d && (ctrl_d_i.jump == JUMP_JAL);
  // A stalled X must not redirect again on the next cycle
  assign osquash_x = val_x && !stall_x && redirect_x_i;

  assign squash_f = val_f && (osquash_d || osquash_x);
  assign squash_d = val_d && osquash_x;

  assign reg_en_f = !stall_f || squash_f;
  assign reg_en_d = !stall_d || squash_d;
  assign reg_en_x = !stall_x;
  assign reg_en_m = !stall_m;

  assign next_val_f = val_f && !stall_f && !squash_f;
  assign next_val_d = val_d && !stall_d && !squash_d;
  assign next_val_x = val_x && !stall_x;
  assign next_val_m = val_m && !stall_m;

  // ------------------------------
  // Pipeline registers
  // ------------------------------

  // Keeps fetch quiet for one cycle after reset
  always_ff @(posedge clk) begin
    reset_q <= reset;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      val_f <= 1'b0;
      val_d <= 1'b0;
      val_x <= 1'b0;
      val_m <= 1'b0;
      val_w <= 1'b0;
    end else begin
      // F is valid once a request went out
      if (reg_en_f) val_f <= imem_req_val_o;
      if (reg_en_d) val_d <= next_val_f;
      if (reg_en_x) val_x <= next_val_d;
      if (reg_en_m) val_m <= next_val_x;
      val_w <= next_val_m;
    end
  end

  always_ff @(posedge clk) begin
    if (reg_en_x) begin
      ctrl_x <= ctrl_d_i;
    end
    if (reg_en_m) begin
      mem_op_m <= ctrl_x.mem_op;
      wb_sel_m <= ctrl_x.wb_sel;
      rf_wen_m <= ctrl_x.rf_wen_pending;
      waddr_m  <= ctrl_x.rf_waddr;
    end
    rf_wen_w <= rf_wen_m;
    waddr_w  <= waddr_m;
  end

  // ------------------------------
  // Memory strobes
  // ------------------------------

  assign imem_req_val_o   = reg_en_f && !reset && !reset_q;
  assign imem_resp_rdy_o  = val_f && reg_en_f;
  assign imem_resp_drop_o = squash_f;

  assign dmem_req_val_o  = val_x && !stall_x && (ctrl_x.mem_op != MEM_NONE);
  assign dmem_req_type_o = ctrl_x.mem_op;
  assign dmem_resp_rdy_o = val_m && !stall_m && (mem_op_m != MEM_NONE);

  // ------------------------------
  // Stage outputs
  // ------------------------------

  always_comb begin
    dest_x_o.wen     = val_x && ctrl_x.rf_wen_pending;
    dest_x_o.addr    = ctrl_x.rf_waddr;
    dest_x_o.is_load = ctrl_x.mem_op == MEM_LOAD;
    dest_m_o.wen     = val_m && rf_wen_m;
    dest_m_o.addr    = waddr_m;
    dest_m_o.is_load = mem_op_m == MEM_LOAD;
    // Load data is in the W pipeline register already
    dest_w_o.wen     = val_w && rf_wen_w;
    dest_w_o.addr    = waddr_w;
    dest_w_o.is_load = 1'b0;
  end

  assign xbr_o.val     = val_x;
  assign xbr_o.br_type = ctrl_x.br_type;
  assign xbr_o.jump    = ctrl_x.jump;

  // Redirect from X overrides a JAL in D
  always_comb begin
    fetch_ctrl_o.reg_en = reg_en_f;
    if (redirect_x_i) begin
      fetch_ctrl_o.pc_sel = pc_sel_x_i;
    end else if (osquash_d) begin
      fetch_ctrl_o.pc_sel = PC_JAL;
    end else begin
      fetch_ctrl_o.pc_sel = PC_PLUS4;
    end
  end

  always_comb begin
    decode_ctrl_o.reg_en   = reg_en_d;
    decode_ctrl_o.op1_byp  = val_d ? op1_byp_i : BYP_RF;
    decode_ctrl_o.op2_byp  = val_d ? op2_byp_i : BYP_RF;
    decode_ctrl_o.op1_sel  = ctrl_d_i.op1_sel;
    decode_ctrl_o.op2_sel  = ctrl_d_i.op2_sel;
    decode_ctrl_o.imm_type = ctrl_d_i.imm_type;
  end

  assign exec_ctrl_o.reg_en = reg_en_x;
  assign exec_ctrl_o.alu_fn = ctrl_x.alu_fn;
  assign exec_ctrl_o.ex_sel = ctrl_x.ex_sel;

  assign mem_ctrl_o.reg_en = reg_en_m;
  assign mem_ctrl_o.wb_sel = wb_sel_m;

  assign wb_ctrl_o.reg_en   = 1'b1;
  assign wb_ctrl_o.rf_waddr = waddr_w;
  assign wb_ctrl_o.rf_wen   = val_w && rf_wen_w;

  assign commit_o = val_w;

  // ------------------------------
  // Assertions
  // ------------------------------

  // X stall on a busy data memory keeps the request back
  a_dmem_req_rdy: assert property (@(posedge clk) disable iff (reset)
    dmem_req_val_o |-> dmem_req_rdy_i);

  a_drop_val_f: assert property (@(posedge clk) disable iff (reset)
    imem_resp_drop_o |-> val_f);

  // Environment must take each fetch request
  a_imem_req_rdy: assert property (@(posedge clk) disable iff (reset)
    imem_req_val_o |-> imem_req_rdy_i);

endmodule

`default_nettype wire

//--- src/rv_ctrl_pkg.sv
// Shared encodings and control structs for the RV32 pipeline control unit
// Enum values must match the datapath mux encodings
`default_nettype none

package rv_ctrl_pkg;

  localparam int REG_ADDR_W = 5;
  localparam int XLEN       = 32;

  // RV32 major opcodes handled here
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLT  = 4'd5,
    ALU_SLTU = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SRL  = 4'd8,
    ALU_SLL  = 4'd9,
    ALU_CP2  = 4'd12  // pass operand 2 through
  } alu_fn_e;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_type_e;
  typedef enum logic {OP1_RF, OP1_PC} op1_sel_e;
  typedef enum logic {OP2_RF, OP2_IMM} op2_sel_e;
  typedef enum logic [1:0] {BYP_RF, BYP_X, BYP_M, BYP_W} byp_sel_e;
  typedef enum logic {EX_ALU, EX_PC4} ex_sel_e;
  typedef enum logic {WB_EX, WB_MEM} wb_sel_e;

  // Bit 0 set means a memory access
  typedef enum logic [1:0] {
    MEM_NONE  = 2'b00,
    MEM_LOAD  = 2'b01,
    MEM_STORE = 2'b11
  } mem_op_e;

  typedef enum logic [2:0] {
    BR_NONE = 3'd0,
    BR_BNE  = 3'd1,
    BR_BEQ  = 3'd2,
    BR_BLT  = 3'd3,
    BR_BGE  = 3'd4,
    BR_BLTU = 3'd5,
    BR_BGEU = 3'd6
  } br_type_e;

  typedef enum logic [1:0] {
    JUMP_NONE = 2'b00,
    JUMP_JAL  = 2'b10,
    JUMP_JALR = 2'b11
  } jump_e;

  typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JAL, PC_JALR} pc_sel_e;

  // Decoded D-stage control word, all-zero is a bubble
  typedef struct packed {
    jump_e                 jump;
    br_type_e              br_type;
    imm_type_e             imm_type;
    op1_sel_e              op1_sel;
    op2_sel_e              op2_sel;
    logic                  rs1_en;
    logic                  rs2_en;
    alu_fn_e               alu_fn;
    ex_sel_e               ex_sel;
    mem_op_e               mem_op;
    wb_sel_e               wb_sel;
    logic                  rf_wen_pending;
    logic [REG_ADDR_W-1:0] rf_waddr;
  } ctrl_word_t;

  // Pending write of one stage, wen already qualified by stage valid
  typedef struct packed {
    logic                  wen;
    logic [REG_ADDR_W-1:0] addr;
    logic                  is_load;
  } dest_info_t;

  typedef struct packed {
    logic eq;
    logic lt;
    logic ltu;
  } br_cond_t;

  typedef struct packed {
    logic     val;
    br_type_e br_type;
    jump_e    jump;
  } x_branch_t;

  typedef struct packed {
    logic    reg_en;
    pc_sel_e pc_sel;
  } fetch_ctrl_t;

  typedef struct packed {
    logic      reg_en;
    byp_sel_e  op1_byp;
    byp_sel_e  op2_byp;
    op1_sel_e  op1_sel;
    op2_sel_e  op2_sel;
    imm_type_e imm_type;
  } decode_ctrl_t;

  typedef struct packed {
    logic    reg_en;
    alu_fn_e alu_fn;
    ex_sel_e ex_sel;
  } exec_ctrl_t;

  typedef struct packed {
    logic    reg_en;
    wb_sel_e wb_sel;
  } mem_ctrl_t;

  typedef struct packed {
    logic                  reg_en;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic                  rf_wen;
  } wb_ctrl_t;

endpackage

`default_nettype wire

//--- src/rv_pipe_ctrl.sv
// Five-stage RV32I pipeline control top level
// inst_d_i must hold the D-stage instruction, br_cond_i the X-stage compare flags
`default_nettype none

module rv_pipe_ctrl import rv_ctrl_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  // Instruction memory
  output logic            imem_req_val_o,
  input  logic            imem_req_rdy_i,
  input  logic            imem_resp_val_i,
  output logic            imem_resp_rdy_o,
  output logic            imem_resp_drop_o,
  // Data memory
  output logic            dmem_req_val_o,
  input  logic            dmem_req_rdy_i,
  output mem_op_e         dmem_req_type_o,
  input  logic            dmem_resp_val_i,
  output logic            dmem_resp_rdy_o,
  // Datapath status
  input  logic [XLEN-1:0] inst_d_i,
  input  br_cond_t        br_cond_i,
  // Datapath control
  output fetch_ctrl_t     fetch_ctrl_o,
  output decode_ctrl_t    decode_ctrl_o,
  output exec_ctrl_t      exec_ctrl_o,
  output mem_ctrl_t       mem_ctrl_o,
  output wb_ctrl_t        wb_ctrl_o,
  output logic            commit_o
);

  ctrl_word_t ctrl_d;
  byp_sel_e   op1_byp, op2_byp;
  logic       load_use;
  logic       redirect_x;
  pc_sel_e    pc_sel_x;
  dest_info_t dest_x, dest_m, dest_w;
  x_branch_t  xbr;

  inst_decoder inst_decoder_i (
    .inst_i (inst_d_i),
    .ctrl_o (ctrl_d)
  );

  // Source fields rs1 and rs2 of the D instruction
  operand_hazard operand_hazard_i (
    .ctrl_i     (ctrl_d),
    .rs1_i      (inst_d_i[19:15]),
    .rs2_i      (inst_d_i[24:20]),
    .dest_x_i   (dest_x),
    .dest_m_i   (dest_m),
    .dest_w_i   (dest_w),
    .op1_byp_o  (op1_byp),
    .op2_byp_o  (op2_byp),
    .load_use_o (load_use)
  );

  branch_resolver branch_resolver_i (
    .xbr_i      (xbr),
    .cond_i     (br_cond_i),
    .redirect_o (redirect_x),
    .pc_sel_o   (pc_sel_x)
  );

  pipe_ctrl pipe_ctrl_i (
    .clk              (clk),
    .reset            (reset),
    .ctrl_d_i         (ctrl_d),
    .op1_byp_i        (op1_byp),
    .op2_byp_i        (op2_byp),
    .load_use_i       (load_use),
    .redirect_x_i     (redirect_x),
    .pc_sel_x_i       (pc_sel_x),
    .imem_req_val_o   (imem_req_val_o),
    .imem_req_rdy_i   (imem_req_rdy_i),
    .imem_resp_val_i  (imem_resp_val_i),
    .imem_resp_rdy_o  (imem_resp_rdy_o),
    .imem_resp_drop_o (imem_resp_drop_o),
    .dmem_req_val_o   (dmem_req_val_o),
    .dmem_req_rdy_i   (dmem_req_rdy_i),
    .dmem_req_type_o  (dmem_req_type_o),
    .dmem_resp_val_i  (dmem_resp_val_i),
    .dmem_resp_rdy_o  (dmem_resp_rdy_o),
    .dest_x_o         (dest_x),
    .dest_m_o         (dest_m),
    .dest_w_o         (dest_w),
    .xbr_o            (xbr),
    .fetch_ctrl_o     (fetch_ctrl_o),
    .decode_ctrl_o    (decode_ctrl_o),
    .exec_ctrl_o      (exec_ctrl_o),
    .mem_ctrl_o       (mem_ctrl_o),
    .wb_ctrl_o        (wb_ctrl_o),
    .commit_o         (commit_o)
  );

endmodule

`default_nettype wire

//--- tests/rv_pipe_ctrl_tb.sv
// Random instruction stream against a shadow pipeline of the control unit
// imem_req_rdy_i stays high for an always-ready instruction memory
// Only ADD, ADDI, LW, SW, BEQ, JAL and JALR on x0 to x3 are generated
`default_nettype none

module rv_pipe_ctrl_tb import rv_ctrl_pkg::*; ();

  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DLY  = 2;
  localparam int N_COMMITS  = 300;
  localparam int MAX_CYCLES = 6000;

  logic            clk;
  logic            reset;
  logic            imem_req_val, imem_req_rdy, imem_resp_val, imem_resp_rdy, imem_resp_drop;
  logic            dmem_req_val, dmem_req_rdy, dmem_resp_val, dmem_resp_rdy;
  mem_op_e         dmem_req_type;
  logic [XLEN-1:0] inst_d;
  br_cond_t        br_cond;
  fetch_ctrl_t     fetch_ctrl;
  decode_ctrl_t    decode_ctrl;
  exec_ctrl_t      exec_ctrl;
  mem_ctrl_t       mem_ctrl;
  wb_ctrl_t        wb_ctrl;
  logic            commit;

  // Shadow pipeline with one instruction word and one valid bit per stage
  logic            f_val, d_val, x_val, m_val, w_val;
  logic [XLEN-1:0] d_inst, x_inst, m_inst, w_inst;
  logic            squash_d_exp;
  logic            after_reset;
  int              errors;
  int              commits;
  int              cycles;
  int              hits [1:6];

  rv_pipe_ctrl rv_pipe_ctrl_i (
    .clk              (clk),
    .reset            (reset),
    .imem_req_val_o   (imem_req_val),
    .imem_req_rdy_i   (imem_req_rdy),
    .imem_resp_val_i  (imem_resp_val),
    .imem_resp_rdy_o  (imem_resp_rdy),
    .imem_resp_drop_o (imem_resp_drop),
    .dmem_req_val_o   (dmem_req_val),
    .dmem_req_rdy_i   (dmem_req_rdy),
    .dmem_req_type_o  (dmem_req_type),
    .dmem_resp_val_i  (dmem_resp_val),
    .dmem_resp_rdy_o  (dmem_resp_rdy),
    .inst_d_i         (inst_d),
    .br_cond_i        (br_cond),
    .fetch_ctrl_o     (fetch_ctrl),
    .decode_ctrl_o    (decode_ctrl),
    .exec_ctrl_o      (exec_ctrl),
    .mem_ctrl_o       (mem_ctrl),
    .wb_ctrl_o        (wb_ctrl),
    .commit_o         (commit)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ------------------------------
  // ISA field helpers
  // ------------------------------

  function automatic logic writes_rd(input logic [XLEN-1:0] inst);
    return inst[6:0] inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_JAL, OPC_JALR};
  endfunction

  function automatic logic uses_rs1(input logic [XLEN-1:0] inst);
    return inst[6:0] inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE, OPC_JALR, OPC_BRANCH};
  endfunction

  function automatic logic uses_rs2(input logic [XLEN-1:0] inst);
    return inst[6:0] inside {OPC_OP, OPC_STORE, OPC_BRANCH};
  endfunction

  function automatic mem_op_e mem_kind(input logic [XLEN-1:0] inst);
    if (inst[6:0] == OPC_LOAD) begin
      return MEM_LOAD;
    end
    if (inst[6:0] == OPC_STORE) begin
      return MEM_STORE;
    end
    return MEM_NONE;
  endfunction

  // Immediate format by opcode
  function automatic imm_type_e imm_kind(input logic [XLEN-1:0] inst);
    case (inst[6:0])
      OPC_STORE:  return IMM_S;
      OPC_BRANCH: return IMM_B;
      OPC_JAL:    return IMM_J;
      default:    return IMM_I;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] random_inst();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    int unsigned kind;
    rd   = 5'($urandom_range(3));
    rs1  = 5'($urandom_range(3));
    rs2  = 5'($urandom_range(3));
    imm  = 12'($urandom);
    kind = $urandom_range(6);
    case (kind)
      0: return {7'b0000000, rs2, rs1, 3'b000, rd, OPC_OP};
      1: return {imm, rs1, 3'b000, rd, OPC_OP_IMM};
      2: return {imm, rs1, 3'b010, rd, OPC_LOAD};
      3: return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
      4: return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], OPC_BRANCH};
      5: return {imm, 8'h00, rd, OPC_JAL};
      default: return {imm, rs1, 3'b000, rd, OPC_JALR};
    endcase
  endfunction

  // Youngest writer among X, M and W but never a load in X
  function automatic byp_sel_e expect_byp(input logic used, input logic [4:0] rs);
    if (!d_val || !used || rs == 5'd0) begin
      return BYP_RF;
    end
    if (x_val && writes_rd(x_inst) && x_inst[11:7] == rs && x_inst[6:0] != OPC_LOAD) begin
      return BYP_X;
    end
    if (m_val && writes_rd(m_inst) && m_inst[11:7] == rs) begin
      return BYP_M;
    end
    if (w_val && writes_rd(w_inst) && w_inst[11:7] == rs) begin
      return BYP_W;
    end
    return BYP_RF;
  endfunction

  task automatic flag_error(input string msg);
    errors++;
    $display("** Error at %0t: %s", $time, msg);
  endtask

  // ------------------------------
  // Per-cycle checks
  // ------------------------------

  task automatic check_cycle();
    logic     x_mem, m_mem, load_use, x_redirect, d_jal, squash_f;
    logic     ostall_f, ostall_x, ostall_m;
    logic     exp_f_en, exp_d_en, exp_x_en, exp_m_en;
    logic     d_sel_ok, x_sel_ok, m_sel_ok;
    pc_sel_e  exp_pc;
    byp_sel_e exp_byp1, exp_byp2;
    // Quiet strobes in reset and one cycle after
    if (reset || after_reset) begin
      hits[1]++;
      assert (!imem_req_val && !dmem_req_val && !commit && !wb_ctrl.rf_wen)
        else flag_error("strobe active during reset or on the cycle after it");
      squash_d_exp = 1'b0;
      return;
    end
    x_mem    = x_val && (mem_kind(x_inst) != MEM_NONE);
    m_mem    = m_val && (mem_kind(m_inst) != MEM_NONE);
    load_use = d_val && x_val && (x_inst[6:0] == OPC_LOAD) && (x_inst[11:7] != 5'd0) &&
               ((uses_rs1(d_inst) && d_inst[19:15] == x_inst[11:7]) ||
                (uses_rs2(d_inst) && d_inst[24:20] == x_inst[11:7]));
    ostall_f = f_val && !imem_resp_val;
    ostall_x = x_mem && !dmem_req_rdy;
    ostall_m = m_mem && !dmem_resp_val;
    x_redirect = x_val && (((x_inst[6:0] == OPC_BRANCH) && br_cond.eq) ||
                           (x_inst[6:0] == OPC_JALR));
    d_jal      = d_val && (d_inst[6:0] == OPC_JAL);
    // Stall reaches back from the originating stage and squash overrides it
    exp_m_en     = !ostall_m;
    exp_x_en     = !(x_val && (ostall_x || ostall_m));
    squash_d_exp = d_val && x_redirect && exp_x_en;
    squash_f     = f_val && (d_jal || (x_redirect && exp_x_en));
    exp_d_en     = !(d_val && (load_use || ostall_x || ostall_m)) || squash_d_exp;
    exp_f_en     = !(f_val && (ostall_f || load_use || ostall_x || ostall_m)) || squash_f;
    assert (fetch_ctrl.reg_en == exp_f_en && decode_ctrl.reg_en == exp_d_en &&
            exec_ctrl.reg_en == exp_x_en && mem_ctrl.reg_en == exp_m_en)
      else flag_error($sformatf("enables F/D/X/M %b%b%b%b, expected %b%b%b%b",
                      fetch_ctrl.reg_en, decode_ctrl.reg_en, exec_ctrl.reg_en,
                      mem_ctrl.reg_en, exp_f_en, exp_d_en, exp_x_en, exp_m_en));
    assert (imem_req_val == exp_f_en && imem_resp_rdy == (f_val && exp_f_en) &&
            dmem_req_val == (x_mem && exp_x_en) && dmem_resp_rdy == (m_mem && exp_m_en))
      else flag_error("memory strobe does not match stage state");
    // Bypass selects
    exp_byp1 = expect_byp(uses_rs1(d_inst), d_inst[19:15]);
    exp_byp2 = expect_byp(uses_rs2(d_inst), d_inst[24:20]);
    if (exp_byp1 != BYP_RF || exp_byp2 != BYP_RF) begin
      hits[2]++;
    end
    assert (decode_ctrl.op1_byp == exp_byp1 && decode_ctrl.op2_byp == exp_byp2)
      else flag_error($sformatf("bypass %0d/%0d, expected %0d/%0d", decode_ctrl.op1_byp,
                      decode_ctrl.op2_byp, exp_byp1, exp_byp2));
    // Datapath selects follow the instruction held in each stage
    d_sel_ok = !d_val ||
               ((!uses_rs1(d_inst) || decode_ctrl.op1_sel == OP1_RF) &&
                (d_inst[6:0] == OPC_JAL ||
                 decode_ctrl.op2_sel ==
                   ((d_inst[6:0] inside {OPC_OP, OPC_BRANCH}) ? OP2_RF : OP2_IMM)) &&
                (d_inst[6:0] == OPC_OP || decode_ctrl.imm_type == imm_kind(d_inst)));
    x_sel_ok = !x_val ||
               ((x_inst[6:0] inside {OPC_BRANCH, OPC_JAL} || exec_ctrl.alu_fn == ALU_ADD) &&
                (!writes_rd(x_inst) ||
                 exec_ctrl.ex_sel ==
                   ((x_inst[6:0] inside {OPC_JAL, OPC_JALR}) ? EX_PC4 : EX_ALU)));
    m_sel_ok = !m_val || !writes_rd(m_inst) ||
               mem_ctrl.wb_sel == ((m_inst[6:0] == OPC_LOAD) ? WB_MEM : WB_EX);
    assert (d_sel_ok && x_sel_ok && m_sel_ok && wb_ctrl.reg_en)
      else flag_error($sformatf("datapath selects wrong in D %b X %b M %b, W enable %b",
                      !d_sel_ok, !x_sel_ok, !m_sel_ok, wb_ctrl.reg_en));
    if (load_use) begin
      hits[3]++;
      assert (!decode_ctrl.reg_en && (!f_val || !fetch_ctrl.reg_en))
        else flag_error("load-use hazard did not hold F and D");
    end
    // Data memory back-pressure on X
    if (ostall_x) begin
      hits[4]++;
      assert (!exec_ctrl.reg_en && !dmem_req_val)
        else flag_error("X memory op not held while dmem_req_rdy is low");
    end
    if (dmem_req_val) begin
      assert (dmem_req_type == mem_kind(x_inst))
        else flag_error($sformatf("dmem_req_type %0d, expected %0d", dmem_req_type,
                        mem_kind(x_inst)));
    end
    // Redirect priority
    if (x_redirect) begin
      exp_pc = (x_inst[6:0] == OPC_JALR) ? PC_JALR : PC_BRANCH;
      hits[5]++;
    end else if (d_jal) begin
      exp_pc = PC_JAL;
      hits[5]++;
    end else begin
      exp_pc = PC_PLUS4;
    end
    assert (fetch_ctrl.pc_sel == exp_pc && imem_resp_drop == squash_f)
      else flag_error($sformatf("pc_sel %0d drop %b, expected %0d drop %b",
                      fetch_ctrl.pc_sel, imem_resp_drop, exp_pc, squash_f));
    // Write-back
    assert (commit == w_val)
      else flag_error($sformatf("commit %b, expected %b", commit, w_val));
    if (commit) begin
      commits++;
      hits[6]++;
      assert (wb_ctrl.rf_wen == writes_rd(w_inst) &&
              (!wb_ctrl.rf_wen || wb_ctrl.rf_waddr == w_inst[11:7]))
        else flag_error($sformatf("rf_wen %b waddr %0d, expected %b waddr %0d",
                        wb_ctrl.rf_wen, wb_ctrl.rf_waddr, writes_rd(w_inst), w_inst[11:7]));
    end
  endtask

  // Oldest stage first so each stage reads the old value of the one before
  task automatic advance_shadow();
    if (reset) begin
      f_val = 1'b0;
      d_val = 1'b0;
      x_val = 1'b0;
      m_val = 1'b0;
      w_val = 1'b0;
      return;
    end
    w_val  = m_val && mem_ctrl.reg_en;
    w_inst = m_inst;
    if (mem_ctrl.reg_en) begin
      m_val  = x_val && exec_ctrl.reg_en;
      m_inst = x_inst;
    end
    if (exec_ctrl.reg_en) begin
      x_val  = d_val && decode_ctrl.reg_en && !squash_d_exp;
      x_inst = d_inst;
    end
    if (decode_ctrl.reg_en) begin
      d_val  = f_val && fetch_ctrl.reg_en && !imem_resp_drop;
      d_inst = random_inst();
    end
    if (fetch_ctrl.reg_en) begin
      f_val = imem_req_val;
    end
  endtask

  // Roughly one strobe in four withheld
  task automatic drive_inputs();
    inst_d        = d_inst;
    imem_resp_val = ($urandom_range(3) != 0);
    dmem_req_rdy  = ($urandom_range(3) != 0);
    dmem_resp_val = ($urandom_range(3) != 0);
    br_cond       = 3'($urandom);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial begin
    void'($urandom(32'h5fff_49d2));
    reset         = 1'b1;
    imem_req_rdy  = 1'b1;
    imem_resp_val = 1'b0;
    dmem_req_rdy  = 1'b0;
    dmem_resp_val = 1'b0;
    inst_d        = '0;
    br_cond       = '0;
    f_val         = 1'b0;
    d_val         = 1'b0;
    x_val         = 1'b0;
    m_val         = 1'b0;
    w_val         = 1'b0;
    d_inst        = '0;
    x_inst        = '0;
    m_inst        = '0;
    w_inst        = '0;
    squash_d_exp  = 1'b0;
    after_reset   = 1'b0;
    errors        = 0;
    commits       = 0;
    cycles        = 0;
    hits          = '{default: 0};
    // Reset covers the first three rising edges
    while (commits < N_COMMITS && cycles < MAX_CYCLES) begin
      @(posedge clk);
      #DRIVE_DLY;
      cycles++;
      reset       = (cycles < 3);
      after_reset = (cycles == 3);
      drive_inputs();
      @(negedge clk);
      check_cycle();
      advance_shadow();
    end
    if (commits < N_COMMITS) begin
      $display("Timeout: only %0d of %0d instructions committed in %0d cycles",
               commits, N_COMMITS, cycles);
      errors++;
    end
    for (int i = 1; i <= 6; i++) begin
      if (hits[i] == 0) begin
        $display("Check %0d was never exercised by the stimulus", i);
        errors++;
      end
    end
    $display("Cycles: %0d, commits: %0d, errors: %0d", cycles, commits, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
